// File: hw/iosys_pkg.sv
// ------------------------------------------------------------------
// bus widths and memory map of the console I/O subsystem, referenced
// by scoped name from every block that decodes or carries bus traffic
// ------------------------------------------------------------------
`default_nettype none

package iosys_pkg;

    // soft-core bus
    typedef logic [31:0] bus_word_t;
    typedef logic [31:0] bus_addr_t;
    typedef logic [3:0]  bus_strb_t;      // all zero for a read

    // sdram port of the console memory controller
    typedef logic [22:0] sdram_addr_t;    // halfword-pair address, bit 1 picks the half
    typedef logic [15:0] sdram_data_t;

    // R L X A RT LT DN UP START SELECT Y B
    typedef logic [11:0] joy_t;

    // register map
    localparam bus_addr_t REG_CHAR     = 32'h0200_0000;  // bits 25:24 switch the overlay
    localparam bus_addr_t REG_ROM_CTRL = 32'h0200_0030;  // 1 starts a load, 0 ends it
    localparam bus_addr_t REG_ROM_DATA = 32'h0200_0034;  // 4 bytes per write
    localparam bus_addr_t REG_JOY      = 32'h0200_0040;

    // everything below this goes to sdram
    localparam bus_addr_t RAM_BYTES    = 32'h0080_0000;  // 8 MiB

endpackage

`default_nettype wire

// File: hw/rom_pkg.sv
// ------------------------------------------------------------------
// ROM image header fields and byte stream types for the loader
// ------------------------------------------------------------------
`default_nettype none

package rom_pkg;

    // header layout, little endian, 12 bytes
    //   word 0  map_ctrl in byte 0, rom_size in 11:8, ram_size in 19:16
    //   word 1  rom_mask in 23:0
    //   word 2  ram_mask in 23:0
    typedef logic [7:0]  rom_byte_t;
    typedef logic [3:0]  rom_size_t;      // size code, not a byte count
    typedef logic [23:0] rom_mask_t;
    typedef logic [7:0]  map_ctrl_t;      // mapper control byte
    typedef logic [1:0]  hdr_idx_t;

    localparam int HDR_WORDS = 3;         // words before the payload starts

endpackage

`default_nettype wire

// File: hw/io_regs.sv
// ------------------------------------------------------------------
// bus decode and result stage: register hits, overlay flag, joystick
// readback, and the ready / read data returned to the bus master
// ------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module io_regs (
    input  wire                       wclk,
    input  wire                       resetn,

    input  wire                       mem_valid,
    input  wire iosys_pkg::bus_addr_t mem_addr,
    input  wire iosys_pkg::bus_word_t mem_wdata,
    input  wire iosys_pkg::bus_strb_t mem_wstrb,
    output logic                      mem_ready,
    output iosys_pkg::bus_word_t      mem_rdata,

    input  wire iosys_pkg::joy_t      joy1,
    input  wire iosys_pkg::joy_t      joy2,
    output logic                      overlay,

    output logic                      rom_ctrl_we,
    output logic                      rom_data_we,
    input  wire                       rom_busy,

    output logic                      ram_sel,
    input  wire                       ram_ready,
    input  wire iosys_pkg::bus_word_t ram_rdata
);

    logic char_hit;
    logic ctrl_hit;
    logic data_hit;
    logic joy_hit;
    logic ram_hit;
    logic is_write;
    logic data_stall;

    assign char_hit = mem_valid && (mem_addr == iosys_pkg::REG_CHAR);
    assign ctrl_hit = mem_valid && (mem_addr == iosys_pkg::REG_ROM_CTRL);
    assign data_hit = mem_valid && (mem_addr == iosys_pkg::REG_ROM_DATA);
    assign joy_hit  = mem_valid && (mem_addr == iosys_pkg::REG_JOY);
    assign ram_hit  = mem_valid && (mem_addr < iosys_pkg::RAM_BYTES);

    assign is_write   = |mem_wstrb;
    assign data_stall = data_hit && is_write && rom_busy;   // loader still shifting

    assign ram_sel     = ram_hit;
    assign rom_ctrl_we = ctrl_hit && is_write;
    assign rom_data_we = data_hit && is_write && !rom_busy;

    // non-ram accesses finish in the cycle they are seen, unmapped ones included
    assign mem_ready = ram_ready || (mem_valid && !ram_hit && !data_stall);

    always_comb begin
        if (ram_ready) begin
            mem_rdata = ram_rdata;
        end else if (joy_hit) begin
            mem_rdata = {4'b0000, joy2, 4'b0000, joy1};
        end else begin
            mem_rdata = '0;
        end
    end

    // osd overlay on/off, on after reset
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            overlay <= 1'b1;
        end else if (char_hit && mem_wstrb[0]) begin
            case (mem_wdata[25:24])
                2'd1:    overlay <= 1'b1;
                2'd2:    overlay <= 1'b0;
                default: ;                  // 0 and 3 keep the flag
            endcase
        end
    end

    // the bridge ready pulse has to land while the master still holds the request
    assert property (@(posedge wclk) disable iff (!resetn) mem_ready |-> mem_valid)
        else $error("mem_ready raised with no request pending");

endmodule

`default_nettype wire

// File: hw/rom_loader.sv
// ------------------------------------------------------------------
// ROM loader: takes the 3-word header into metadata registers, then
// turns each payload word into four rom_do bytes, lowest byte first
// ------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rom_loader (
    input  wire                       wclk,
    input  wire                       resetn,

    input  wire                       rom_ctrl_we,
    input  wire                       rom_data_we,
    input  wire iosys_pkg::bus_word_t wdata,
    output logic                      rom_busy,

    output logic                      rom_loading,
    output rom_pkg::rom_byte_t        rom_do,
    output logic                      rom_do_valid,

    output rom_pkg::map_ctrl_t        map_ctrl,
    output rom_pkg::rom_size_t        rom_size,
    output rom_pkg::rom_size_t        ram_size,
    output rom_pkg::rom_mask_t        rom_mask,
    output rom_pkg::rom_mask_t        ram_mask
);

    rom_pkg::hdr_idx_t    hdr_idx;      // header words taken so far
    logic [1:0]           byte_cnt;     // bytes left after the current one
    iosys_pkg::bus_word_t shift_buf;
    logic                 payload_we;

    assign payload_we = rom_data_we &&
                        (hdr_idx == rom_pkg::hdr_idx_t'(rom_pkg::HDR_WORDS));
    assign rom_busy   = (byte_cnt != 2'd0);
    assign rom_do     = shift_buf[7:0];

    // load control and header position
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            rom_loading <= 1'b0;
            hdr_idx     <= '0;
        end else if (rom_ctrl_we && (wdata[7:0] == 8'd1)) begin
            rom_loading <= 1'b1;
            hdr_idx     <= '0;          // next data write is header word 0
        end else if (rom_ctrl_we && (wdata[7:0] == 8'd0)) begin
            rom_loading <= 1'b0;
        end else if (rom_data_we && !payload_we) begin
            hdr_idx <= hdr_idx + 2'd1;
        end
    end

    // metadata from the header words
    always_ff @(posedge wclk) begin
        if (rom_data_we) begin
            case (hdr_idx)
                2'd0: begin
                    map_ctrl <= wdata[7:0];
                    rom_size <= wdata[11:8];
                    ram_size <= wdata[19:16];
                end
                2'd1:    rom_mask <= wdata[23:0];
                2'd2:    ram_mask <= wdata[23:0];
                default: ;                  // payload, handled below
            endcase
        end
    end

    // valid runs for 4 cycles after each payload word
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            byte_cnt     <= 2'd0;
            rom_do_valid <= 1'b0;
        end else if (payload_we) begin
            byte_cnt     <= 2'd3;
            rom_do_valid <= 1'b1;
        end else begin
            if (rom_busy) begin
                byte_cnt <= byte_cnt - 2'd1;
            end
            rom_do_valid <= rom_busy;
        end
    end

    always_ff @(posedge wclk) begin
        if (payload_we) begin
            shift_buf <= wdata;
        end else if (rom_busy) begin
            shift_buf <= {8'h00, shift_buf[31:8]};
        end
    end

    // io_regs must hold the bus while bytes are still going out
    assert property (@(posedge wclk) disable iff (!resetn) rom_data_we |-> !rom_busy)
        else $error("rom data write arrived during the byte stream");

endmodule

`default_nettype wire

// File: hw/sdram_bridge.sv
// ------------------------------------------------------------------
// 32-bit bus to 16-bit sdram bridge: two halfword steps per access,
// low half first, each pulse repeated while the controller sets wait
// ------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sdram_bridge (
    input  wire                         wclk,
    input  wire                         resetn,

    input  wire                         ram_sel,
    input  wire iosys_pkg::bus_addr_t   mem_addr,
    input  wire iosys_pkg::bus_word_t   mem_wdata,
    input  wire iosys_pkg::bus_strb_t   mem_wstrb,
    output logic                        ram_ready,
    output iosys_pkg::bus_word_t        ram_rdata,

    output iosys_pkg::sdram_addr_t      rv_addr,
    output iosys_pkg::sdram_data_t      rv_din,
    output logic [1:0]                  rv_ds,
    output logic                        rv_rd,
    output logic                        rv_wr,
    input  wire iosys_pkg::sdram_data_t rv_dout,
    input  wire                         rv_wait
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FIRST,       // low halfword in flight
        ST_SECOND,      // high halfword in flight
        ST_RD_FIN       // read data on the bus
    } state_t;

    state_t                 state;
    logic                   writing;
    logic                   is_write;
    logic                   pulsed;
    logic                   step_done;
    iosys_pkg::sdram_data_t din_hi;
    logic [1:0]             ds_hi;

    assign is_write  = |mem_wstrb;
    assign pulsed    = rv_rd || rv_wr;
    // wait is judged in the cycle after the pulse
    assign step_done = !pulsed && !rv_wait;

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            writing   <= 1'b0;
            ram_ready <= 1'b0;
            rv_rd     <= 1'b0;
            rv_wr     <= 1'b0;
        end else begin
            ram_ready <= 1'b0;
            rv_rd     <= 1'b0;
            rv_wr     <= 1'b0;
            case (state)
                ST_IDLE: if (ram_sel) begin
                    writing   <= is_write;
                    ram_ready <= is_write;      // posted write, master moves on
                    rv_wr     <= is_write;
                    rv_rd     <= !is_write;
                    state     <= ST_FIRST;
                end
                ST_FIRST: if (!pulsed) begin
                    // retry the low half or start the high half
                    rv_wr <= writing;
                    rv_rd <= !writing;
                    if (!rv_wait) begin
                        state <= ST_SECOND;
                    end
                end
                ST_SECOND: if (!pulsed) begin
                    if (rv_wait) begin
                        rv_wr <= writing;
                        rv_rd <= !writing;
                    end else begin
                        ram_ready <= !writing;
                        state     <= writing ? ST_IDLE : ST_RD_FIN;
                    end
                end
                ST_RD_FIN: state <= ST_IDLE;    // keeps the held request from restarting
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // address, data and read capture
    always_ff @(posedge wclk) begin
        case (state)
            ST_IDLE: if (ram_sel) begin
                rv_addr <= {mem_addr[22:2], 2'b00};
                rv_din  <= mem_wdata[15:0];
                rv_ds   <= is_write ? mem_wstrb[1:0] : 2'b11;
                din_hi  <= mem_wdata[31:16];
                ds_hi   <= is_write ? mem_wstrb[3:2] : 2'b11;
            end
            ST_FIRST: if (step_done) begin
                ram_rdata[15:0] <= rv_dout;
                rv_addr         <= {rv_addr[22:2], 2'b10};
                rv_din          <= din_hi;
                rv_ds           <= ds_hi;
            end
            ST_SECOND: if (step_done) begin
                ram_rdata[31:16] <= rv_dout;
            end
            default: ;
        endcase
    end

    assert property (@(posedge wclk) disable iff (!resetn) !(rv_rd && rv_wr))
        else $error("sdram read and write pulsed together");

endmodule

`default_nettype wire

// File: hw/iosys_core.sv
// ------------------------------------------------------------------
// I/O subsystem top: bus decode, ROM loader and sdram bridge wired
// to the external bus, joystick, ROM stream and sdram ports
// ------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module iosys_core (
    input  wire                         wclk,
    input  wire                         resetn,

    input  wire                         mem_valid,
    input  wire iosys_pkg::bus_addr_t   mem_addr,
    input  wire iosys_pkg::bus_word_t   mem_wdata,
    input  wire iosys_pkg::bus_strb_t   mem_wstrb,
    output logic                        mem_ready,
    output iosys_pkg::bus_word_t        mem_rdata,

    input  wire iosys_pkg::joy_t        joy1,
    input  wire iosys_pkg::joy_t        joy2,
    output logic                        overlay,

    output logic                        rom_loading,
    output rom_pkg::rom_byte_t          rom_do,
    output logic                        rom_do_valid,
    output rom_pkg::map_ctrl_t          map_ctrl,
    output rom_pkg::rom_size_t          rom_size,
    output rom_pkg::rom_size_t          ram_size,
    output rom_pkg::rom_mask_t          rom_mask,
    output rom_pkg::rom_mask_t          ram_mask,

    output iosys_pkg::sdram_addr_t      rv_addr,
    output iosys_pkg::sdram_data_t      rv_din,
    output logic [1:0]                  rv_ds,
    output logic                        rv_rd,
    output logic                        rv_wr,
    input  wire iosys_pkg::sdram_data_t rv_dout,
    input  wire                         rv_wait
);

    logic                 rom_ctrl_we;
    logic                 rom_data_we;
    logic                 rom_busy;     // back-pressure on ROM data writes
    logic                 ram_sel;
    logic                 ram_ready;
    iosys_pkg::bus_word_t ram_rdata;

    io_regs io_regs_i (
        .wclk(wclk), .resetn(resetn),
        .mem_valid(mem_valid), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .joy1(joy1), .joy2(joy2), .overlay(overlay),
        .rom_ctrl_we(rom_ctrl_we), .rom_data_we(rom_data_we), .rom_busy(rom_busy),
        .ram_sel(ram_sel), .ram_ready(ram_ready), .ram_rdata(ram_rdata)
    );

    rom_loader rom_loader_i (
        .wclk(wclk), .resetn(resetn),
        .rom_ctrl_we(rom_ctrl_we), .rom_data_we(rom_data_we), .wdata(mem_wdata),
        .rom_busy(rom_busy), .rom_loading(rom_loading),
        .rom_do(rom_do), .rom_do_valid(rom_do_valid),
        .map_ctrl(map_ctrl), .rom_size(rom_size), .ram_size(ram_size),
        .rom_mask(rom_mask), .ram_mask(ram_mask)
    );

    sdram_bridge sdram_bridge_i (
        .wclk(wclk), .resetn(resetn),
        .ram_sel(ram_sel), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .ram_ready(ram_ready), .ram_rdata(ram_rdata),
        .rv_addr(rv_addr), .rv_din(rv_din), .rv_ds(rv_ds),
        .rv_rd(rv_rd), .rv_wr(rv_wr), .rv_dout(rv_dout), .rv_wait(rv_wait)
    );

endmodule

`default_nettype wire

// File: verification/iosys_tb.sv
// ----------------------------------------------------------------------
// testbench for iosys_core: plays the bus master, models the sdram and
// applies a table of register, ROM loader and RAM steps with checks
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module iosys_tb;

    localparam int BUS_TIMEOUT = 200;   // cycles per bus access
    localparam int DRAIN_TIMEOUT = 100;

    typedef enum logic [3:0] {
        K_WR, K_RD, K_OVL, K_LOAD, K_IDLE, K_MAP, K_RSZ, K_ASZ,
        K_RMSK, K_AMSK, K_STREAM, K_MEM
    } step_kind_e;

    typedef struct packed {
        step_kind_e           kind;
        iosys_pkg::bus_addr_t addr;
        iosys_pkg::bus_word_t wdata;
        iosys_pkg::bus_strb_t strb;
        iosys_pkg::bus_word_t exp_val;
    } step_t;

    logic                   wclk;
    logic                   resetn;
    logic                   mem_valid;
    iosys_pkg::bus_addr_t   mem_addr;
    iosys_pkg::bus_word_t   mem_wdata;
    iosys_pkg::bus_strb_t   mem_wstrb;
    logic                   mem_ready;
    iosys_pkg::bus_word_t   mem_rdata;
    iosys_pkg::joy_t        joy1;
    iosys_pkg::joy_t        joy2;
    logic                   overlay;
    logic                   rom_loading;
    rom_pkg::rom_byte_t     rom_do;
    logic                   rom_do_valid;
    rom_pkg::map_ctrl_t     map_ctrl;
    rom_pkg::rom_size_t     rom_size;
    rom_pkg::rom_size_t     ram_size;
    rom_pkg::rom_mask_t     rom_mask;
    rom_pkg::rom_mask_t     ram_mask;
    iosys_pkg::sdram_addr_t rv_addr;
    iosys_pkg::sdram_data_t rv_din;
    logic [1:0]             rv_ds;
    logic                   rv_rd;
    logic                   rv_wr;
    iosys_pkg::sdram_data_t rv_dout;
    logic                   rv_wait;

    iosys_pkg::sdram_data_t sdram_mem [0:1023];    // 2 KiB window of the sdram
    rom_pkg::rom_byte_t     got_bytes [$];
    rom_pkg::rom_byte_t     exp_bytes [$];
    step_t                  steps [$];
    int                     err_count = 0;
    int                     pass_count = 0;
    int                     fail_count = 0;
    int                     hdr_seen = 0;
    logic                   timed_out = 1'b0;

    iosys_core iosys_core_i (
        .wclk(wclk), .resetn(resetn),
        .mem_valid(mem_valid), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .joy1(joy1), .joy2(joy2), .overlay(overlay),
        .rom_loading(rom_loading), .rom_do(rom_do), .rom_do_valid(rom_do_valid),
        .map_ctrl(map_ctrl), .rom_size(rom_size), .ram_size(ram_size),
        .rom_mask(rom_mask), .ram_mask(ram_mask),
        .rv_addr(rv_addr), .rv_din(rv_din), .rv_ds(rv_ds),
        .rv_rd(rv_rd), .rv_wr(rv_wr), .rv_dout(rv_dout), .rv_wait(rv_wait)
    );

    initial begin
        wclk = 1'b0;
        forever #2 wclk = ~wclk;
    end

    // sdram controller: request seen mid-cycle, wait and data the cycle after
    initial begin : sdram_model
        logic                   rd_req;
        logic                   wr_req;
        logic                   busy;
        iosys_pkg::sdram_addr_t req_addr;
        iosys_pkg::sdram_data_t req_din;
        logic [1:0]             req_ds;
        void'($urandom(62));
        rv_wait = 1'b0;
        rv_dout = '0;
        for (int i = 0; i < 1024; i++) begin
            sdram_mem[i] = 16'(i * 37) ^ 16'hC3A5;
        end
        forever begin
            @(negedge wclk);
            rd_req   = rv_rd;
            wr_req   = rv_wr;
            req_addr = rv_addr;
            req_din  = rv_din;
            req_ds   = rv_ds;
            @(posedge wclk);
            #1;
            busy = (rd_req || wr_req) && (($urandom % 4) == 0);
            rv_wait = busy;     // a busy cycle takes no request
            if (wr_req && !busy && req_ds[0]) begin
                sdram_mem[req_addr[10:1]][7:0] = req_din[7:0];
            end
            if (wr_req && !busy && req_ds[1]) begin
                sdram_mem[req_addr[10:1]][15:8] = req_din[15:8];
            end
            if (rd_req && !busy) begin
                rv_dout = sdram_mem[req_addr[10:1]];
            end
        end
    end

    // collects the ROM byte stream in order
    initial begin
        forever begin
            @(negedge wclk);
            if (rom_do_valid === 1'b1) begin
                got_bytes.push_back(rom_do);
            end
        end
    end

    task automatic check_word(input string name, input iosys_pkg::bus_word_t got,
                              input iosys_pkg::bus_word_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_byte(input string name, input rom_pkg::rom_byte_t got,
                              input rom_pkg::rom_byte_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_mask(input string name, input rom_pkg::rom_mask_t got,
                              input rom_pkg::rom_mask_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_size(input string name, input rom_pkg::rom_size_t got,
                              input rom_pkg::rom_size_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    // called at posedge + 1, returns at posedge + 1 after the handshake edge
    task automatic bus_access(input iosys_pkg::bus_addr_t addr,
                              input iosys_pkg::bus_word_t wdata,
                              input iosys_pkg::bus_strb_t strb,
                              output iosys_pkg::bus_word_t rdata);
        int   cycles;
        logic done;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_wstrb = strb;
        mem_valid = 1'b1;
        cycles = 0;
        done   = 1'b0;
        rdata  = '0;
        while (!done && cycles < BUS_TIMEOUT) begin
            @(negedge wclk);
            if (mem_ready === 1'b1) begin
                done  = 1'b1;
                rdata = mem_rdata;
            end
            @(posedge wclk);
            #1;
            cycles++;
        end
        mem_valid = 1'b0;
        mem_wstrb = '0;
        if (!done) begin
            $display("bus access to %h got no ready within %0d cycles", addr, BUS_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    // expected stream: header words are skipped, payload bytes go out lowest first
    task automatic note_rom_write(input step_t st);
        int b;
        if (st.addr == iosys_pkg::REG_ROM_CTRL && st.wdata[7:0] == 8'd1) begin
            hdr_seen = 0;
        end else if (st.addr == iosys_pkg::REG_ROM_DATA) begin
            if (hdr_seen < rom_pkg::HDR_WORDS) begin
                hdr_seen++;
            end else begin
                for (b = 0; b < 4; b++) begin
                    exp_bytes.push_back(st.wdata[8*b +: 8]);
                end
            end
        end
    endtask

    task automatic check_stream();
        int cycles;
        int k;
        cycles = 0;
        while ((got_bytes.size() < exp_bytes.size() || rom_do_valid) &&
               cycles < DRAIN_TIMEOUT) begin
            @(posedge wclk);
            #1;
            cycles++;
        end
        if (got_bytes.size() != exp_bytes.size()) begin
            $display("rom stream gave %0d bytes where %0d were written",
                     got_bytes.size(), exp_bytes.size());
            err_count++;
        end else begin
            for (k = 0; k < exp_bytes.size(); k++) begin
                check_byte("rom_do", got_bytes[k], exp_bytes[k]);
            end
        end
        got_bytes.delete();
        exp_bytes.delete();
    endtask

    task automatic run_step(input int num, input step_t st);
        int                   errs_before;
        iosys_pkg::bus_word_t rdata;
        iosys_pkg::bus_addr_t hi_addr;
        errs_before = err_count;
        hi_addr = st.addr + 32'd2;
        case (st.kind)
            K_WR: begin
                bus_access(st.addr, st.wdata, st.strb, rdata);
                note_rom_write(st);
            end
            K_RD: begin
                bus_access(st.addr, '0, '0, rdata);
                if (!timed_out) begin
                    check_word("mem_rdata", rdata, st.exp_val);
                end
            end
            K_OVL:  check_flag("overlay", overlay, st.exp_val[0]);
            K_LOAD: check_flag("rom_loading", rom_loading, st.exp_val[0]);
            K_IDLE: begin
                check_flag("rom_do_valid", rom_do_valid, st.exp_val[0]);
                check_flag("rv_rd", rv_rd, st.exp_val[0]);
                check_flag("rv_wr", rv_wr, st.exp_val[0]);
            end
            K_MAP:    check_byte("map_ctrl", map_ctrl, st.exp_val[7:0]);
            K_RSZ:    check_size("rom_size", rom_size, st.exp_val[3:0]);
            K_ASZ:    check_size("ram_size", ram_size, st.exp_val[3:0]);
            K_RMSK:   check_mask("rom_mask", rom_mask, st.exp_val[23:0]);
            K_AMSK:   check_mask("ram_mask", ram_mask, st.exp_val[23:0]);
            K_STREAM: check_stream();
            K_MEM: check_word("sdram halfwords",
                              {sdram_mem[hi_addr[10:1]], sdram_mem[st.addr[10:1]]},
                              st.exp_val);
            default: ;
        endcase
        if (err_count == errs_before && !timed_out) begin
            pass_count++;
            $display("test %0d %s addr %h ok", num, st.kind.name(), st.addr);
        end else begin
            fail_count++;
            $display("test %0d %s addr %h failed", num, st.kind.name(), st.addr);
        end
    endtask

    task automatic add_step(input step_kind_e kind, input iosys_pkg::bus_addr_t addr,
                            input iosys_pkg::bus_word_t wdata,
                            input iosys_pkg::bus_strb_t strb,
                            input iosys_pkg::bus_word_t exp_val);
        steps.push_back('{kind, addr, wdata, strb, exp_val});
    endtask

    task automatic build_table();
        // reset state
        add_step(K_OVL,  '0, '0, '0, 32'h1);
        add_step(K_LOAD, '0, '0, '0, 32'h0);
        add_step(K_IDLE, '0, '0, '0, 32'h0);
        // overlay 2 clears, 1 sets, 3 keeps
        add_step(K_WR,  iosys_pkg::REG_CHAR, 32'h0200_0000, 4'hF, '0);
        add_step(K_OVL, '0, '0, '0, 32'h0);
        add_step(K_WR,  iosys_pkg::REG_CHAR, 32'h0100_0000, 4'hF, '0);
        add_step(K_OVL, '0, '0, '0, 32'h1);
        add_step(K_WR,  iosys_pkg::REG_CHAR, 32'h0300_0000, 4'hF, '0);
        add_step(K_OVL, '0, '0, '0, 32'h1);
        add_step(K_RD,  iosys_pkg::REG_JOY, '0, '0, 32'h03E1_0A5C);
        add_step(K_RD,  32'h0200_0050, '0, '0, 32'h0);     // unmapped
        // ROM header
        add_step(K_WR,   iosys_pkg::REG_ROM_CTRL, 32'h1, 4'hF, '0);
        add_step(K_LOAD, '0, '0, '0, 32'h1);
        add_step(K_WR,   iosys_pkg::REG_ROM_DATA, 32'h0005_0342, 4'hF, '0);
        add_step(K_WR,   iosys_pkg::REG_ROM_DATA, 32'hAB1F_FFFF, 4'hF, '0);
        add_step(K_WR,   iosys_pkg::REG_ROM_DATA, 32'hCD00_7FFF, 4'hF, '0);
        add_step(K_MAP,  '0, '0, '0, 32'h42);
        add_step(K_RSZ,  '0, '0, '0, 32'h3);
        add_step(K_ASZ,  '0, '0, '0, 32'h5);
        add_step(K_RMSK, '0, '0, '0, 32'h001F_FFFF);
        add_step(K_AMSK, '0, '0, '0, 32'h0000_7FFF);
        // payload back to back, later words wait for the stream
        add_step(K_WR,     iosys_pkg::REG_ROM_DATA, 32'h4433_2211, 4'hF, '0);
        add_step(K_WR,     iosys_pkg::REG_ROM_DATA, 32'h8877_6655, 4'hF, '0);
        add_step(K_WR,     iosys_pkg::REG_ROM_DATA, 32'hDEAD_BEEF, 4'hF, '0);
        add_step(K_STREAM, '0, '0, '0, '0);
        add_step(K_WR,     iosys_pkg::REG_ROM_CTRL, 32'h0, 4'hF, '0);
        add_step(K_LOAD,   '0, '0, '0, 32'h0);
        // RAM with byte strobes
        add_step(K_WR, 32'h100, 32'h1122_3344, 4'hF, '0);
        add_step(K_WR, 32'h100, 32'hAABB_CCDD, 4'h5, '0);
        add_step(K_WR, 32'h104, 32'h5566_7788, 4'hF, '0);
        add_step(K_WR, 32'h104, 32'h99AA_BBCC, 4'hC, '0);
        add_step(K_WR, 32'h108, 32'hCAFE_F00D, 4'hF, '0);
        add_step(K_WR, 32'h108, 32'h1234_5678, 4'h2, '0);
        add_step(K_RD,  32'h100, '0, '0, 32'h11BB_33DD);
        add_step(K_RD,  32'h104, '0, '0, 32'h99AA_7788);
        add_step(K_RD,  32'h108, '0, '0, 32'hCAFE_560D);
        add_step(K_MEM, 32'h100, '0, '0, 32'h11BB_33DD);
        add_step(K_MEM, 32'h104, '0, '0, 32'h99AA_7788);
        add_step(K_MEM, 32'h108, '0, '0, 32'hCAFE_560D);
        // read straight after a posted write is held until the bridge is idle
        add_step(K_WR, 32'h200, 32'h0F1E_2D3C, 4'hF, '0);
        add_step(K_RD, 32'h200, '0, '0, 32'h0F1E_2D3C);
    endtask

    initial begin
        int i;
        resetn    = 1'b0;
        mem_valid = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        joy1      = 12'hA5C;
        joy2      = 12'h3E1;
        build_table();
        repeat (8) @(posedge wclk);
        #1;
        resetn = 1'b1;
        for (i = 0; i < steps.size() && !timed_out; i++) begin
            run_step(i, steps[i]);
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/iosys_pkg.sv
hw/rom_pkg.sv
hw/io_regs.sv
hw/rom_loader.sv
hw/sdram_bridge.sv
hw/iosys_core.sv
verification/iosys_tb.sv

// File: Makefile
# Verilator build and run of the I/O subsystem testbench

VERILATOR ?= verilator
TOP       ?= iosys_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
